// ==== Bender.yml ====
package:
  name: pulse_synth

sources:
  - verilog/synth_pkg.sv
  - verilog/fir_pkg.sv
  - verilog/tone_generator.sv
  - verilog/sample_history.sv
  - verilog/tap_counter.sv
  - verilog/fir_sequencer.sv
  - verilog/fir_mac.sv
  - verilog/pulse_synth_top.sv
  - target: simulation
    files:
      - verif/pulse_synth_tb.sv

// ==== flist.f ====
verilog/synth_pkg.sv
verilog/fir_pkg.sv
verilog/tone_generator.sv
verilog/sample_history.sv
verilog/tap_counter.sv
verilog/fir_sequencer.sv
verilog/fir_mac.sv
verilog/pulse_synth_top.sv
verif/pulse_synth_tb.sv

// ==== verif/pulse_synth_tb.sv ====
/* Directed testbench for the pulse voice that drives notes, ticks and credits and checks
   every output sample and its timing against a reference model of the voice and filter. */
`timescale 1ns/1ns
`default_nettype none

module pulse_synth_tb;

    localparam int TICK_GAP       = 50;
    localparam int LATENCY        = fir_pkg::FIR_TAPS + 5;
    localparam int TOTAL_TICKS    = 16 + 32 + 80 + 80 + 80 + 24;
    localparam int TIMEOUT_CYCLES = TOTAL_TICKS * TICK_GAP + 2000;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  midi_rdy;
    synth_pkg::midi_cmd_t  midi_cmd;
    synth_pkg::midi_data_t midi_data0;
    synth_pkg::midi_data_t midi_data1;
    logic                  sample_tick;
    logic                  credit_return;
    logic                  sample_out_valid;
    synth_pkg::sample_t    sample_out;

    int   cycle      = 0;
    int   errors     = 0;
    int   checks     = 0;
    int   out_count  = 0;
    int   lat_checks = 0;
    logic auto_credit = 1'b1;

    // Reference model state with hist[0] as the newest smoothed sample
    synth_pkg::sample_t hist [fir_pkg::FIR_TAPS] = '{default: '0};
    synth_pkg::sample_t smooth_ref  = '0;
    int                 phase_ref   = 0;
    int                 note_edge   = 0;
    int                 note_level  = 0;
    int                 half_ref    = 1;
    int                 credits_ref = fir_pkg::CREDIT_MAX;
    logic               held_ref    = 1'b0;
    int                 skipped_ref = 0;
    synth_pkg::sample_t exp_q [$];
    int                 exp_edge_q [$];

    pulse_synth_top pulse_synth_top_inst (
        .clk              (clk),
        .reset            (reset),
        .midi_rdy         (midi_rdy),
        .midi_cmd         (midi_cmd),
        .midi_data0       (midi_data0),
        .midi_data1       (midi_data1),
        .sample_tick      (sample_tick),
        .credit_return    (credit_return),
        .sample_out_valid (sample_out_valid),
        .sample_out       (sample_out)
    );

    always #5 clk = ~clk;

    // Edge counter that also bounds the run
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", cycle);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic check_sample(input string name, input synth_pkg::sample_t got,
                                input synth_pkg::sample_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    function automatic synth_pkg::sample_t fir_reference();
        longint acc = 0;
        for (int k = 0; k < fir_pkg::FIR_TAPS; k++) begin
            acc += longint'(hist[k]) * longint'(fir_pkg::FIR_COEFS[k]);
        end
        return synth_pkg::sample_t'(acc >>> fir_pkg::OUT_SHIFT);
    endfunction

    // Completed block goes out, waits for a credit or drops behind a waiting result
    task automatic queue_result(input int tick_edge);
        if (held_ref) begin
            skipped_ref++;
        end else if (credits_ref > 0) begin
            exp_q.push_back(fir_reference());
            exp_edge_q.push_back(tick_edge + LATENCY);
            if (!auto_credit) begin
                credits_ref--;
            end
        end else begin
            held_ref = 1'b1;
            exp_q.push_back(fir_reference());
            exp_edge_q.push_back(-1);
        end
    endtask

    task automatic advance_voice(input int tick_edge);
        int toggles;
        int lvl;
        // Level flips every half-period plus one edges after the note event
        toggles    = (tick_edge - note_edge - 1) / (half_ref + 1);
        lvl        = (toggles % 2 == 1) ? -note_level : note_level;
        smooth_ref = synth_pkg::sample_t'((lvl + int'(smooth_ref)) >>> 1);
        for (int k = fir_pkg::FIR_TAPS - 1; k > 0; k--) begin
            hist[k] = hist[k - 1];
        end
        hist[0] = smooth_ref;
        phase_ref++;
        if (phase_ref == fir_pkg::DECIM) begin
            phase_ref = 0;
            queue_result(tick_edge);
        end
    endtask

    task automatic restore_credit();
        if (held_ref) begin
            held_ref = 1'b0;
        end else begin
            credits_ref++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Drive and observe on each falling edge
    // ------------------------------------------------------------------------
    task automatic observe();
        int exp_edge;
        if (sample_out_valid === 1'b1) begin
            out_count++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("Output pulse at cycle %0d when no sample was expected", cycle + 1);
            end else begin
                check_sample("sample_out", sample_out, exp_q.pop_front());
                exp_edge = exp_edge_q.pop_front();
                if (exp_edge >= 0) begin
                    lat_checks++;
                    check_count("sample_out_valid cycle", cycle + 1, exp_edge);
                end
            end
        end
    endtask

    task automatic step(input logic tick, input logic ret);
        @(negedge clk);
        observe();
        midi_rdy      = 1'b0;
        sample_tick   = tick;
        credit_return = auto_credit ? sample_out_valid : ret;
        if (tick) begin
            advance_voice(cycle + 1);
        end
        if (ret && !auto_credit) begin
            restore_credit();
        end
    endtask

    task automatic send_midi(input synth_pkg::midi_cmd_t cmd, input synth_pkg::midi_data_t note,
                             input synth_pkg::midi_data_t vel);
        @(negedge clk);
        observe();
        midi_rdy      = 1'b1;
        midi_cmd      = cmd;
        midi_data0    = note;
        midi_data1    = vel;
        sample_tick   = 1'b0;
        credit_return = auto_credit ? sample_out_valid : 1'b0;
        note_edge     = cycle + 1;
        if (cmd == synth_pkg::MIDI_CMD_NOTE_ON) begin
            note_level = int'(vel) << synth_pkg::VELOCITY_SHIFT;
            half_ref   = int'(synth_pkg::SEMITONE_DIV[note % 12]) >> (note / 12 + 1);
        end else begin
            note_level = 0;
        end
    endtask

    task automatic run_ticks(input int n);
        repeat (n) begin
            step(1'b1, 1'b0);
            repeat (TICK_GAP - 1) step(1'b0, 1'b0);
        end
    endtask

    task automatic expect_outputs(input string name, input int start, input int n);
        check_count(name, out_count - start, n);
        check_count("samples still expected", exp_q.size(), 0);
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic silence_after_reset();
        int start;
        start = out_count;
        check_count("sample_out_valid after reset", int'(sample_out_valid), 0);
        check_sample("sample_out after reset", sample_out, '0);
        run_ticks(16);
        expect_outputs("outputs in silence", start, 2);
    endtask

    task automatic steady_tone();
        int start;
        start = out_count;
        send_midi(synth_pkg::MIDI_CMD_NOTE_ON, 7'd0, 7'($urandom_range(1, 127)));
        run_ticks(32);
        expect_outputs("outputs for steady tone", start, 4);
    endtask

    task automatic toggling_tone();
        int start;
        start = out_count;
        send_midi(synth_pkg::MIDI_CMD_NOTE_ON, 7'd127, 7'($urandom_range(1, 127)));
        run_ticks(80);
        expect_outputs("outputs for toggling tone", start, 10);
    endtask

    task automatic note_off_decay();
        int start;
        start = out_count;
        send_midi(synth_pkg::MIDI_CMD_NOTE_ON, 7'd60, 7'($urandom_range(1, 127)));
        run_ticks(16);
        send_midi(synth_pkg::MIDI_CMD_NOTE_OFF, 7'd60, 7'd0);
        run_ticks(64);
        expect_outputs("outputs for note off", start, 10);
        check_sample("sample_out after decay", sample_out, '0);
    endtask

    // Four blocks use up the credits before one waits and two are dropped
    task automatic credit_backpressure();
        int start;
        int gap;
        auto_credit = 1'b0;
        send_midi(synth_pkg::MIDI_CMD_NOTE_ON, 7'd127, 7'($urandom_range(1, 127)));
        start = out_count;
        run_ticks(56);
        check_count("outputs with credits withheld", out_count - start, fir_pkg::CREDIT_MAX);
        start = out_count;
        for (int i = 0; i < fir_pkg::CREDIT_MAX; i++) begin
            gap = $urandom_range(4, 16);
            repeat (gap) step(1'b0, 1'b0);
            step(1'b0, 1'b1);
        end
        repeat (4) step(1'b0, 1'b0);
        auto_credit = 1'b1;
        run_ticks(24);
        expect_outputs("outputs after credit return", start, 4);
    endtask

    task automatic fixed_latency();
        int start;
        int lat_start;
        start     = out_count;
        lat_start = lat_checks;
        send_midi(synth_pkg::MIDI_CMD_NOTE_ON, 7'($urandom_range(0, 127)),
                  7'($urandom_range(1, 127)));
        run_ticks(24);
        expect_outputs("outputs for latency test", start, 3);
        check_count("latency checks", lat_checks - lat_start, 3);
    endtask

    initial begin
        void'($urandom(87));
        reset         = 1'b1;
        midi_rdy      = 1'b0;
        midi_cmd      = '0;
        midi_data0    = '0;
        midi_data1    = '0;
        sample_tick   = 1'b0;
        credit_return = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        silence_after_reset();
        steady_tone();
        toggling_tone();
        note_off_decay();
        credit_backpressure();
        fixed_latency();

        $display("Checks: %0d, errors: %0d, outputs: %0d, skipped blocks: %0d",
                 checks, errors, out_count, skipped_ref);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/fir_mac.sv ====
/* Multiply-accumulate for the FIR: coefficient lookup, product register and accumulator.
   Loads the scaled sum into result_sample and flags it with acc_done. */
`timescale 1ns/1ns
`default_nettype none

module fir_mac (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    tap_active,
    input  wire fir_pkg::tap_idx_t  tap_idx,
    input  wire                    tap_last,
    input  wire synth_pkg::sample_t tap_sample,
    output logic                   acc_done,
    output synth_pkg::sample_t     result_sample
);

    fir_pkg::tap_idx_t idx_d;
    logic              active_d;
    logic              first_d;
    logic              last_d;
    fir_pkg::coef_t    coef;
    fir_pkg::acc_t     prod;
    logic              prod_valid;
    logic              prod_first;
    fir_pkg::acc_t     acc;
    fir_pkg::acc_t     acc_next;

    // Index delayed to line up with the registered history read
    assign coef     = fir_pkg::FIR_COEFS[idx_d];
    assign acc_next = (prod_first ? '0 : acc) + prod;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active_d   <= 1'b0;
            first_d    <= 1'b0;
            last_d     <= 1'b0;
            prod_valid <= 1'b0;
            prod_first <= 1'b0;
            acc_done   <= 1'b0;
        end else begin
            active_d   <= tap_active;
            first_d    <= tap_active && (tap_idx == '0);
            last_d     <= tap_last;
            prod_valid <= active_d;
            prod_first <= first_d;
            acc_done   <= last_d;
        end
    end

    always_ff @(posedge clk) begin
        idx_d <= tap_idx;
        prod  <= tap_sample * coef;
        if (prod_valid) begin
            acc <= acc_next;
        end
    end

    // last_d coincides with the final product
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result_sample <= '0;
        end else if (last_d) begin
            result_sample <= synth_pkg::sample_t'(acc_next >>> fir_pkg::OUT_SHIFT);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fir_pkg.sv ====
/* Decimating FIR definitions: tap count, decimation, coefficients, accumulator and credits.
   Referenced by scoped names from the filter blocks and the testbench. */
`default_nettype none

package fir_pkg;

    // ------------------------------------------------------------------------
    // Filter geometry
    // ------------------------------------------------------------------------
    localparam int FIR_TAPS = 32;
    localparam int DECIM    = 8;

    typedef logic [$clog2(FIR_TAPS)-1:0] tap_idx_t;
    typedef logic signed [17:0]          coef_t;
    typedef logic signed [47:0]          acc_t;

    // Accumulator to sample scaling
    localparam int OUT_SHIFT = 15;

    // Index 0 weights the newest sample
    localparam coef_t FIR_COEFS [FIR_TAPS] = '{
        18'h3FFFE, 18'h3FFFE, 18'h3FFFF, 18'h00006,
        18'h00013, 18'h00027, 18'h00040, 18'h00058,
        18'h00065, 18'h0005B, 18'h0002B, 18'h3FFCC,
        18'h3FF3B, 18'h3FE82, 18'h3FDBC, 18'h3FD13,
        18'h3FCBE, 18'h3FCF9, 18'h3FDFF, 18'h3FFF7,
        18'h002F0, 18'h006D5, 18'h00B6A, 18'h01054,
        18'h0151B, 18'h01942, 18'h01C54, 18'h01DF5,
        18'h01DF5, 18'h01C54, 18'h01942, 18'h0151B
    };

    // ------------------------------------------------------------------------
    // Output flow control
    // ------------------------------------------------------------------------
    localparam int CREDIT_MAX = 4;

    typedef logic [2:0] credit_t;

endpackage

`default_nettype wire

// ==== verilog/fir_sequencer.sv ====
/* Decimation phase, FIR run control and credit-based output handshake.
   One run per DECIM smoothed samples; results wait in HOLD until a credit is free. */
`timescale 1ns/1ns
`default_nettype none

module fir_sequencer (
    input  wire  clk,
    input  wire  reset,
    input  wire  smooth_valid,
    input  wire  acc_done,
    input  wire  credit_return,
    output logic run_start,
    output logic sample_out_valid
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        HOLD
    } state_t;

    typedef logic [$clog2(fir_pkg::DECIM)-1:0] phase_t;

    state_t           state;
    phase_t           phase;
    fir_pkg::credit_t credits;
    logic             block_done;
    logic             result_ready;
    logic             credit_avail;

    assign block_done   = smooth_valid && (phase == phase_t'(fir_pkg::DECIM - 1));
    assign result_ready = (state == HOLD) || ((state == RUN) && acc_done);
    assign credit_avail = (credits != '0);

    // Same cycle as acc_done when a credit is free
    assign sample_out_valid = result_ready && credit_avail;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase <= '0;
        end else if (block_done) begin
            phase <= '0;
        end else if (smooth_valid) begin
            phase <= phase + 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Run FSM, a block completing outside IDLE is dropped
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= IDLE;
            run_start <= 1'b0;
        end else begin
            run_start <= 1'b0;
            case (state)
                IDLE: begin
                    if (block_done) begin
                        state     <= RUN;
                        run_start <= 1'b1;
                    end
                end
                RUN: begin
                    if (acc_done) begin
                        state <= credit_avail ? IDLE : HOLD;
                    end
                end
                HOLD: begin
                    if (credit_avail) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credits <= fir_pkg::credit_t'(fir_pkg::CREDIT_MAX);
        end else begin
            credits <= credits + fir_pkg::credit_t'(credit_return)
                               - fir_pkg::credit_t'(sample_out_valid);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/pulse_synth_top.sv ====
/* MIDI pulse voice with a 32-tap decimate-by-8 output filter and credit flow control.
   Connects the tone generator, sample history, sequencer, tap counter and MAC. */
`timescale 1ns/1ns
`default_nettype none

module pulse_synth_top (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      midi_rdy,
    input  wire synth_pkg::midi_cmd_t  midi_cmd,
    input  wire synth_pkg::midi_data_t midi_data0,
    input  wire synth_pkg::midi_data_t midi_data1,
    input  wire                      sample_tick,
    input  wire                      credit_return,
    output logic                     sample_out_valid,
    output synth_pkg::sample_t       sample_out
);

    synth_pkg::sample_t smooth_sample;
    logic               smooth_valid;
    logic               run_start;
    fir_pkg::tap_idx_t  tap_idx;
    logic               tap_active;
    logic               tap_last;
    synth_pkg::sample_t tap_sample;
    logic               acc_done;

    tone_generator tone_generator_inst (
        .clk           (clk),
        .reset         (reset),
        .midi_rdy      (midi_rdy),
        .midi_cmd      (midi_cmd),
        .midi_data0    (midi_data0),
        .midi_data1    (midi_data1),
        .sample_tick   (sample_tick),
        .smooth_sample (smooth_sample),
        .smooth_valid  (smooth_valid)
    );

    sample_history sample_history_inst (
        .clk           (clk),
        .reset         (reset),
        .smooth_valid  (smooth_valid),
        .smooth_sample (smooth_sample),
        .run_start     (run_start),
        .tap_idx       (tap_idx),
        .tap_sample    (tap_sample)
    );

    fir_sequencer fir_sequencer_inst (
        .clk              (clk),
        .reset            (reset),
        .smooth_valid     (smooth_valid),
        .acc_done         (acc_done),
        .credit_return    (credit_return),
        .run_start        (run_start),
        .sample_out_valid (sample_out_valid)
    );

    tap_counter tap_counter_inst (
        .clk        (clk),
        .reset      (reset),
        .run_start  (run_start),
        .tap_idx    (tap_idx),
        .tap_active (tap_active),
        .tap_last   (tap_last)
    );

    fir_mac fir_mac_inst (
        .clk           (clk),
        .reset         (reset),
        .tap_active    (tap_active),
        .tap_idx       (tap_idx),
        .tap_last      (tap_last),
        .tap_sample    (tap_sample),
        .acc_done      (acc_done),
        .result_sample (sample_out)
    );

endmodule

`default_nettype wire

// ==== verilog/sample_history.sv ====
/* Ring buffer of the last 32 smoothed samples, read newest-first during a FIR run.
   The read base is frozen at run start so one run sees a fixed window. */
`timescale 1ns/1ns
`default_nettype none

module sample_history (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    smooth_valid,
    input  wire synth_pkg::sample_t smooth_sample,
    input  wire                    run_start,
    input  wire fir_pkg::tap_idx_t  tap_idx,
    output synth_pkg::sample_t     tap_sample
);

    synth_pkg::sample_t mem [fir_pkg::FIR_TAPS];
    fir_pkg::tap_idx_t  wr_ptr;
    fir_pkg::tap_idx_t  rd_base;
    fir_pkg::tap_idx_t  rd_addr;

    // Wraps around the 32 entries
    assign rd_addr = rd_base - tap_idx;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            for (int i = 0; i < fir_pkg::FIR_TAPS; i++) begin
                mem[i] <= '0;
            end
        end else if (smooth_valid) begin
            mem[wr_ptr] <= smooth_sample;
            wr_ptr      <= wr_ptr + 1'b1;
        end
    end

    // Newest sample sits one behind the write pointer
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_base <= '0;
        end else if (run_start) begin
            rd_base <= wr_ptr - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        tap_sample <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== verilog/synth_pkg.sv ====
/* Definitions for the tone side of the voice: MIDI fields, samples and the note table.
   Referenced by scoped names from the RTL and the testbench. */
`default_nettype none

package synth_pkg;

    // ------------------------------------------------------------------------
    // MIDI
    // ------------------------------------------------------------------------
    typedef logic [3:0] midi_cmd_t;
    typedef logic [6:0] midi_data_t;

    localparam midi_cmd_t MIDI_CMD_NOTE_ON  = 4'h9;
    localparam midi_cmd_t MIDI_CMD_NOTE_OFF = 4'h8;

    // ------------------------------------------------------------------------
    // Samples and note timing
    // ------------------------------------------------------------------------
    typedef logic signed [17:0] sample_t;
    typedef logic        [23:0] half_period_t;

    // Velocity lands in bits 15:9 of the level
    localparam int VELOCITY_SHIFT = 9;

    // Dividers of notes 0 to 11, each octave up halves them
    localparam half_period_t SEMITONE_DIV [12] = '{
        24'h5d5084, 24'h5813c2, 24'h532240, 24'h4e77c5,
        24'h4a1054, 24'h45e82b, 24'h41fbbc, 24'h3e47ac,
        24'h3ac8d3, 24'h377c32, 24'h345efa, 24'h316e80
    };

endpackage

`default_nettype wire

// ==== verilog/tap_counter.sv ====
/* Repeat counter for one FIR run: steps the tap index through every tap after run start.
   Flags the cycle after the final tap with a one-cycle pulse. */
`timescale 1ns/1ns
`default_nettype none

module tap_counter (
    input  wire               clk,
    input  wire               reset,
    input  wire               run_start,
    output fir_pkg::tap_idx_t tap_idx,
    output logic              tap_active,
    output logic              tap_last
);

    logic at_end;

    assign at_end = tap_active && (tap_idx == fir_pkg::tap_idx_t'(fir_pkg::FIR_TAPS - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tap_idx    <= '0;
            tap_active <= 1'b0;
            tap_last   <= 1'b0;
        end else begin
            tap_last <= at_end;
            if (run_start) begin
                tap_idx    <= '0;
                tap_active <= 1'b1;
            end else if (tap_active) begin
                // Index wraps back to zero on the last tap
                tap_idx <= tap_idx + 1'b1;
                if (at_end) begin
                    tap_active <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/tone_generator.sv ====
/* Pulse voice: decodes note on/off, times the square wave and smooths it once per 8x tick.
   The smoothed sample feeds the decimating filter. */
`timescale 1ns/1ns
`default_nettype none

module tone_generator (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      midi_rdy,
    input  wire synth_pkg::midi_cmd_t  midi_cmd,
    input  wire synth_pkg::midi_data_t midi_data0,
    input  wire synth_pkg::midi_data_t midi_data1,
    input  wire                      sample_tick,
    output synth_pkg::sample_t       smooth_sample,
    output logic                     smooth_valid
);

    logic                    note_on;
    logic                    note_off;
    logic [3:0]              semitone;
    logic [3:0]              octave;
    synth_pkg::half_period_t half_period;
    synth_pkg::half_period_t timer;
    synth_pkg::sample_t      level;
    synth_pkg::sample_t      vel_level;
    logic signed [18:0]      smooth_sum;

    assign note_on  = midi_rdy && (midi_cmd == synth_pkg::MIDI_CMD_NOTE_ON);
    assign note_off = midi_rdy && (midi_cmd == synth_pkg::MIDI_CMD_NOTE_OFF);

    // Table gives a full period, so one extra shift for half
    assign half_period = synth_pkg::SEMITONE_DIV[semitone] >> (octave + 4'd1);
    assign vel_level   = synth_pkg::sample_t'({1'b0, midi_data1}) << synth_pkg::VELOCITY_SHIFT;
    assign smooth_sum  = 19'(level) + 19'(smooth_sample);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            semitone <= 4'd0;
            octave   <= 4'd0;
        end else if (note_on) begin
            semitone <= 4'(midi_data0 % 7'd12);
            octave   <= 4'(midi_data0 / 7'd12);
        end
    end

    // ------------------------------------------------------------------------
    // Half-period timer and square level
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            timer <= '0;
            level <= '0;
        end else if (note_on) begin
            timer <= '0;
            level <= vel_level;
        end else if (note_off) begin
            timer <= '0;
            level <= '0;
        end else if (timer == half_period) begin
            timer <= '0;
            level <= -level;
        end else begin
            timer <= timer + 1'b1;
        end
    end

    // One-pole smoothing at the tick rate
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            smooth_sample <= '0;
            smooth_valid  <= 1'b0;
        end else begin
            smooth_valid <= sample_tick;
            if (sample_tick) begin
                smooth_sample <= synth_pkg::sample_t'(smooth_sum >>> 1);
            end
        end
    end

endmodule

`default_nettype wire
